/* Bender.yml */
package:
  name: ex_stage

sources:
  - hdl/ex_pkg.sv
  - hdl/ex_adder_if.sv
  - hdl/ex_alu.sv
  - hdl/ex_multdiv.sv
  - hdl/ex_writeback.sv
  - hdl/ex_stage.sv
  - target: test
    files:
      - test/ex_stage_asserts.sv
      - test/ex_stage_tb.sv

/* ex_stage.f */
hdl/ex_pkg.sv
hdl/ex_adder_if.sv
hdl/ex_alu.sv
hdl/ex_multdiv.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
test/ex_stage_asserts.sv
test/ex_stage_tb.sv

/* hdl/ex_adder_if.sv */
`timescale 1ns/1ps

interface ex_adder_if;

  // multiplier owns the alu adder while high
  logic        mult_en;
  // operands go straight into the adder, no negation
  logic [32:0] mult_operand_a;
  logic [32:0] mult_operand_b;
  // full sum including carry out
  logic [33:0] adder_result_ext;

  modport md (
    output mult_en,
    output mult_operand_a,
    output mult_operand_b,
    input  adder_result_ext
  );

  modport alu (
    input  mult_en,
    input  mult_operand_a,
    input  mult_operand_b,
    output adder_result_ext
  );

endinterface

/* hdl/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu import ex_pkg::*;
(
  input  alu_op_e     operator_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  ex_adder_if.alu     adder,
  output logic [31:0] result_o,
  output logic        comparison_result_o
);

  logic [31:0] operand_a_rev;

  // bit reversed operand a feeds the shifter for left shifts
  for (genvar k = 0; k < 32; k++)
  begin : g_rev_a
    assign operand_a_rev[k] = operand_a_i[31-k];
  end

  ////////////////////////////////////////////////////////////
  // adder
  ////////////////////////////////////////////////////////////

  logic        adder_op_b_negate;
  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic [32:0] operand_b_neg;
  logic [31:0] adder_result;

  // subtract and every compare use a - b
  always_comb
  begin
    adder_op_b_negate = 1'b0;
    unique case (operator_i)
      ALU_SUB,
      ALU_EQ,    ALU_NE,
      ALU_GTU,   ALU_GEU,
      ALU_LTU,   ALU_LEU,
      ALU_GTS,   ALU_GES,
      ALU_LTS,   ALU_LES,
      ALU_SLTS,  ALU_SLTU,
      ALU_SLETS, ALU_SLETU: adder_op_b_negate = 1'b1;
      default: ;
    endcase
  end

  // trailing 1 on a and inverted b give the +1 of two's complement
  assign adder_in_a    = adder.mult_en ? adder.mult_operand_a : {operand_a_i, 1'b1};
  assign adder_in_b    = {operand_b_i, 1'b0};
  assign operand_b_neg = adder.mult_en ? adder.mult_operand_b
                                       : adder_in_b ^ {33{adder_op_b_negate}};

  assign adder.adder_result_ext = {1'b0, adder_in_a} + {1'b0, operand_b_neg};
  // drop the carry-in position
  assign adder_result           = adder.adder_result_ext[32:1];

  ////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////

  logic        shift_left;
  logic        shift_arithmetic;
  logic [4:0]  shift_amt;
  logic [31:0] shift_op_a;
  logic [32:0] shift_op_a_ext;
  logic [32:0] shift_right_ext;
  logic [31:0] shift_right_result;
  logic [31:0] shift_left_result;
  logic [31:0] shift_result;

  assign shift_left       = (operator_i == ALU_SLL);
  assign shift_arithmetic = (operator_i == ALU_SRA);
  // only the low five bits of b count
  assign shift_amt        = operand_b_i[4:0];

  // one right shifter, sll goes through it reversed
  assign shift_op_a         = shift_left ? operand_a_rev : operand_a_i;
  // extra top bit carries the fill value, zero unless sra
  assign shift_op_a_ext     = {shift_arithmetic & shift_op_a[31], shift_op_a};
  assign shift_right_ext    = $signed(shift_op_a_ext) >>> shift_amt;
  assign shift_right_result = shift_right_ext[31:0];

  for (genvar j = 0; j < 32; j++)
  begin : g_rev_res
    assign shift_left_result[j] = shift_right_result[31-j];
  end

  assign shift_result = shift_left ? shift_left_result : shift_right_result;

  ////////////////////////////////////////////////////////////
  // comparator
  ////////////////////////////////////////////////////////////

  logic is_equal;
  logic is_greater_equal;
  logic cmp_signed;
  logic cmp_result;

  assign cmp_signed = (operator_i == ALU_GTS)  || (operator_i == ALU_GES)  ||
                      (operator_i == ALU_LTS)  || (operator_i == ALU_LES)  ||
                      (operator_i == ALU_SLTS) || (operator_i == ALU_SLETS);

  assign is_equal = (adder_result == 32'b0);

  // same signs: look at the difference
  // different signs: a wins unsigned when a[31] set, signed when clear
  always_comb
  begin
    if ((operand_a_i[31] ^ operand_b_i[31]) == 1'b0)
      is_greater_equal = (adder_result[31] == 1'b0);
    else
      is_greater_equal = operand_a_i[31] ^ cmp_signed;
  end

  always_comb
  begin
    cmp_result = is_equal;
    unique case (operator_i)
      ALU_EQ:            cmp_result = is_equal;
      ALU_NE:            cmp_result = ~is_equal;
      ALU_GTS, ALU_GTU:  cmp_result = is_greater_equal && ~is_equal;
      ALU_GES, ALU_GEU:  cmp_result = is_greater_equal;
      ALU_LTS, ALU_SLTS,
      ALU_LTU, ALU_SLTU: cmp_result = ~is_greater_equal;
      ALU_LES, ALU_LEU,
      ALU_SLETS,
      ALU_SLETU:         cmp_result = ~is_greater_equal || is_equal;
      default: ;
    endcase
  end

  assign comparison_result_o = cmp_result;

  ////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o = '0;
    unique case (operator_i)
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_SLL,
      ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_EQ,    ALU_NE,
      ALU_GTU,   ALU_GEU,
      ALU_LTU,   ALU_LEU,
      ALU_GTS,   ALU_GES,
      ALU_LTS,   ALU_LES,
      ALU_SLTS,  ALU_SLTU,
      ALU_SLETS, ALU_SLETU: result_o = {31'b0, cmp_result};
      default: ;
    endcase
  end

endmodule

/* hdl/ex_multdiv.sv */
`timescale 1ns/1ps

module ex_multdiv import ex_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  input  md_op_e      op_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  ex_adder_if.md      adder,
  output logic        busy_o,
  output logic        done_o,
  output logic [31:0] result_o
);

  localparam int CNT_W = $clog2(MD_STEPS);

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_STEP,
    MD_FINISH
  } md_state_e;

  md_state_e  state_q;
  md_state_e  state_d;
  logic [CNT_W-1:0] step_cnt_q;
  logic [CNT_W-1:0] step_cnt_d;
  logic       start_accept;
  logic       last_step;

  // payload, loaded on start
  logic [31:0] mcand_q;
  logic [63:0] acc_q;
  logic [63:0] acc_step;
  md_op_e      op_q;

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  // a start while busy is dropped here
  assign start_accept = start_i && (state_q == MD_IDLE);
  assign last_step    = (step_cnt_q == CNT_W'(MD_STEPS - 1));

  always_comb
  begin
    state_d    = state_q;
    step_cnt_d = step_cnt_q;
    unique case (state_q)
      MD_IDLE:
      begin
        if (start_accept)
        begin
          state_d    = MD_STEP;
          step_cnt_d = '0;
        end
      end
      MD_STEP:
      begin
        step_cnt_d = step_cnt_q + 1'b1;
        if (last_step)
          state_d = MD_FINISH;
      end
      // result stays on result_o for the done cycle
      MD_FINISH: state_d = MD_IDLE;
      default:   state_d = MD_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q    <= MD_IDLE;
      step_cnt_q <= '0;
    end
    else
    begin
      state_q    <= state_d;
      step_cnt_q <= step_cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  // high half plus multiplicand or zero, picked by the current multiplier bit
  assign adder.mult_en        = (state_q == MD_STEP);
  assign adder.mult_operand_a = {1'b0, acc_q[63:32]};
  assign adder.mult_operand_b = {1'b0, acc_q[0] ? mcand_q : 32'b0};

  // 33 bit sum on top, multiplier bits shift out at the bottom
  // bit 33 of the extended sum is always zero for these operands
  assign acc_step = {adder.adder_result_ext[32:0], acc_q[31:1]};

  always_ff @(posedge clk)
  begin
    if (start_accept)
    begin
      mcand_q <= op_a_i;
      acc_q   <= {32'b0, op_b_i};
      op_q    <= op_i;
    end
    else if (state_q == MD_STEP)
    begin
      acc_q <= acc_step;
    end
  end

  assign busy_o   = (state_q != MD_IDLE);
  assign done_o   = (state_q == MD_FINISH);
  assign result_o = (op_q == MD_MULHU) ? acc_q[63:32] : acc_q[31:0];

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // operator field of the alu
  localparam int ALU_OP_WIDTH = 6;

  // one iteration per multiplier bit
  localparam int MD_STEPS = 32;

  ////////////////////////////////////////////////////////////
  // alu operators
  ////////////////////////////////////////////////////////////

  typedef enum logic [ALU_OP_WIDTH-1:0] {
    // arithmetic and logic
    ALU_ADD   = 6'b011000,
    ALU_SUB   = 6'b011001,
    ALU_XOR   = 6'b101111,
    ALU_OR    = 6'b101110,
    ALU_AND   = 6'b010101,
    // shifts
    ALU_SRA   = 6'b100100,
    ALU_SRL   = 6'b100101,
    ALU_SLL   = 6'b100111,
    // branch comparisons
    ALU_LTS   = 6'b000000,
    ALU_LTU   = 6'b000001,
    ALU_LES   = 6'b000100,
    ALU_LEU   = 6'b000101,
    ALU_GTS   = 6'b001000,
    ALU_GTU   = 6'b001001,
    ALU_GES   = 6'b001010,
    ALU_GEU   = 6'b001011,
    ALU_EQ    = 6'b001100,
    ALU_NE    = 6'b001101,
    // set forms, 0 or 1 written to rd
    ALU_SLTS  = 6'b000010,
    ALU_SLTU  = 6'b000011,
    ALU_SLETS = 6'b000110,
    ALU_SLETU = 6'b000111
  } alu_op_e;

  // multiply operators, low or high word of the unsigned product
  typedef enum logic [0:0] {
    MD_MUL   = 1'b0,
    MD_MULHU = 1'b1
  } md_op_e;

endpackage

/* hdl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import ex_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    issue_i,
  input  logic                    is_mult_i,
  input  logic [ALU_OP_WIDTH-1:0] alu_op_i,
  input  md_op_e                  md_op_i,
  input  logic [31:0]             operand_a_i,
  input  logic [31:0]             operand_b_i,
  output logic [31:0]             result_o,
  output logic                    cmp_o,
  output logic                    valid_o,
  output logic                    busy_o
);

  logic        alu_issue;
  logic        md_start;
  logic [31:0] alu_result;
  logic        alu_cmp;
  logic        md_busy;
  logic        md_done;
  logic [31:0] md_result;

  // shared adder path, multiplier to alu
  ex_adder_if adder_bus ();

  ////////////////////////////////////////////////////////////
  // issue decode
  ////////////////////////////////////////////////////////////

  // anything issued while busy is dropped
  assign alu_issue = issue_i & ~is_mult_i & ~busy_o;
  assign md_start  = issue_i &  is_mult_i & ~busy_o;

  ex_alu u_alu (
    .operator_i          (alu_op_e'(alu_op_i)),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .adder               (adder_bus.alu),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp)
  );

  ex_multdiv u_multdiv (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (md_start),
    .op_i     (md_op_i),
    .op_a_i   (operand_a_i),
    .op_b_i   (operand_b_i),
    .adder    (adder_bus.md),
    .busy_o   (md_busy),
    .done_o   (md_done),
    .result_o (md_result)
  );

  ex_writeback u_writeback (
    .clk          (clk),
    .reset_i      (reset_i),
    .alu_issue_i  (alu_issue),
    .alu_result_i (alu_result),
    .alu_cmp_i    (alu_cmp),
    .md_busy_i    (md_busy),
    .md_done_i    (md_done),
    .md_result_i  (md_result),
    .result_o     (result_o),
    .cmp_o        (cmp_o),
    .valid_o      (valid_o),
    .busy_o       (busy_o)
  );

endmodule

/* hdl/ex_writeback.sv */
`timescale 1ns/1ps

module ex_writeback
(
  input  logic        clk,
  input  logic        reset_i,
  // alu side
  input  logic        alu_issue_i,
  input  logic [31:0] alu_result_i,
  input  logic        alu_cmp_i,
  // multiplier side
  input  logic        md_busy_i,
  input  logic        md_done_i,
  input  logic [31:0] md_result_i,
  // stage outputs
  output logic [31:0] result_o,
  output logic        cmp_o,
  output logic        valid_o,
  output logic        busy_o
);

  logic [31:0] result_q;
  logic        cmp_q;
  logic        valid_q;

  ////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////

  // alu issues are blocked while the multiplier runs,
  // so both sources never complete in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      result_q <= '0;
      cmp_q    <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      // one-cycle strobe per completion
      valid_q <= alu_issue_i | md_done_i;
      if (md_done_i)
      begin
        result_q <= md_result_i;
        // products carry no comparison flag
        cmp_q    <= 1'b0;
      end
      else if (alu_issue_i)
      begin
        result_q <= alu_result_i;
        cmp_q    <= alu_cmp_i;
      end
    end
  end

  assign result_o = result_q;
  assign cmp_o    = cmp_q;
  assign valid_o  = valid_q;

  // multiplier stays busy through its done cycle,
  // so busy drops exactly when the product appears here
  assign busy_o = md_busy_i;

endmodule

/* test/ex_stage_asserts.sv */
`timescale 1ns/1ps

module ex_stage_asserts
(
  input logic clk,
  input logic reset_i,
  input logic issue_i,
  input logic is_mult_i,
  input logic valid_o,
  input logic busy_o
);

  // failed assertions so far, read by the testbench
  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////
  // control outputs
  ////////////////////////////////////////////////////////////

  // one strobe per completion, never stretched
  valid_single: assert property (@(posedge clk) disable iff (reset_i)
    valid_o |=> !valid_o)
    else
    begin
      fail_cnt++;
      $error("valid_o high on two cycles in a row");
    end

  // stage comes out of reset idle
  reset_idle: assert property (@(posedge clk)
    reset_i |=> (!valid_o && !busy_o))
    else
    begin
      fail_cnt++;
      $error("valid_o or busy_o set in the cycle after reset");
    end

  // alu result lands one cycle after an accepted issue
  alu_latency: assert property (@(posedge clk) disable iff (reset_i)
    (issue_i && !is_mult_i && !busy_o) |=> valid_o)
    else
    begin
      fail_cnt++;
      $error("alu issue not followed by valid_o");
    end

endmodule

bind ex_stage ex_stage_asserts u_asserts (.*);

/* test/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int N_ARITH      = 40;
  localparam int N_SHIFT      = 30;
  localparam int N_CMP_EACH   = 12;
  localparam int N_MUL        = 20;
  localparam int N_MUL_EDGE   = 8;
  localparam int N_BUSY       = 6;
  // random ops, each compare op, mult edges, busy runs, reset mult and alu
  localparam int N_OPS = N_ARITH + N_SHIFT + 14 * N_CMP_EACH + N_MUL + N_MUL_EDGE +
                         N_BUSY + 2;
  localparam int TIMEOUT_CYCLES = N_OPS * (MD_STEPS + 4) + 2 * RESET_CYCLES;

  logic                    clk;
  logic                    reset_i;
  logic                    issue_i;
  logic                    is_mult_i;
  logic [ALU_OP_WIDTH-1:0] alu_op_i;
  md_op_e                  md_op_i;
  logic [31:0]             operand_a_i;
  logic [31:0]             operand_b_i;
  logic [31:0]             result_o;
  logic                    cmp_o;
  logic                    valid_o;
  logic                    busy_o;

  int cycle_cnt = 0;

  alu_op_e arith_ops [5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
  alu_op_e shift_ops [3] = '{ALU_SLL, ALU_SRL, ALU_SRA};
  alu_op_e cmp_ops [14]  = '{ALU_EQ, ALU_NE, ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU,
                             ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
                             ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU};

  // zero, sign boundaries, all ones and equal pairs
  logic [31:0] edge_a [8] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                              32'h8000_0000, 32'hffff_ffff, 32'h0000_0001, 32'h7fff_ffff};
  logic [31:0] edge_b [8] = '{32'h0000_0000, 32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000,
                              32'h8000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h7fff_ffff};

  ex_stage dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .issue_i     (issue_i),
    .is_mult_i   (is_mult_i),
    .alu_op_i    (alu_op_i),
    .md_op_i     (md_op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (result_o),
    .cmp_o       (cmp_o),
    .valid_o     (valid_o),
    .busy_o      (busy_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit scaled by the op count
  initial
  begin
    forever
    begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
        $display("run timed out waiting for a result after %0d cycles", cycle_cnt);
        $display("TEST FAIL");
        $fatal(1, "timeout");
      end
    end
  end

  // bound checker on the control outputs
  initial
  begin
    wait (dut.u_asserts.fail_cnt != 0);
    $display("assertion on the stage control outputs failed");
    $display("TEST FAIL");
    $fatal(1, "assertion");
  end

  ////////////////////////////////////////////////////////////
  // reference behavior
  ////////////////////////////////////////////////////////////

  function automatic logic is_compare(alu_op_e op);
    case (op)
      ALU_EQ, ALU_NE, ALU_GTU, ALU_GEU, ALU_LTU, ALU_LEU,
      ALU_GTS, ALU_GES, ALU_LTS, ALU_LES,
      ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic expected_cmp(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_EQ:             return a == b;
      ALU_NE:             return a != b;
      ALU_GTU:            return a > b;
      ALU_GEU:            return a >= b;
      ALU_LTU, ALU_SLTU:  return a < b;
      ALU_LEU, ALU_SLETU: return a <= b;
      ALU_GTS:            return $signed(a) > $signed(b);
      ALU_GES:            return $signed(a) >= $signed(b);
      ALU_LTS, ALU_SLTS:  return $signed(a) < $signed(b);
      ALU_LES, ALU_SLETS: return $signed(a) <= $signed(b);
      default:            return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] expected_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return $signed(a) >>> sh;
      default: return {31'b0, expected_cmp(op, a, b)};
    endcase
  endfunction

  // low or high word of the unsigned 64 bit product
  function automatic logic [31:0] expected_product(md_op_e op, logic [31:0] a,
                                                   logic [31:0] b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    return (op == MD_MULHU) ? prod[63:32] : prod[31:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Fail at time %0t: %s (got %h, expected %h)", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // counts falling edges from the issue-sampling edge to valid_o
  task automatic wait_for_valid(output int lat);
    @(negedge clk);
    lat = 1;
    while (valid_o !== 1'b1)
    begin
      @(negedge clk);
      lat++;
    end
  endtask

  task automatic run_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
    int lat;
    @(posedge clk);
    issue_i     <= 1'b1;
    is_mult_i   <= 1'b0;
    alu_op_i    <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    @(posedge clk);
    issue_i <= 1'b0;
    wait_for_valid(lat);
    check_equal(lat, 1, $sformatf("%s valid latency", op.name()));
    check_equal(result_o, expected_alu(op, a, b), $sformatf("%s result", op.name()));
    if (is_compare(op))
      check_equal(cmp_o, expected_cmp(op, a, b), $sformatf("%s flag", op.name()));
    @(negedge clk);
    check_equal(valid_o, 1'b0, "valid_o longer than one cycle");
  endtask

  // extra issue pulses land while the multiplier is busy
  task automatic run_mult(input md_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input int n_pulses);
    int lat;
    @(posedge clk);
    issue_i     <= 1'b1;
    is_mult_i   <= 1'b1;
    md_op_i     <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    @(posedge clk);
    issue_i <= 1'b0;
    @(negedge clk);
    check_equal(busy_o, 1'b1, "busy_o after multiply issue");
    repeat (n_pulses)
    begin
      @(posedge clk);
      issue_i     <= 1'b1;
      is_mult_i   <= 1'($urandom_range(1, 0));
      alu_op_i    <= arith_ops[$urandom_range(4, 0)];
      md_op_i     <= md_op_e'($urandom_range(1, 0));
      operand_a_i <= $urandom;
      operand_b_i <= $urandom;
      @(posedge clk);
      issue_i <= 1'b0;
    end
    wait_for_valid(lat);
    check_equal(busy_o, 1'b0, "busy_o with product valid");
    check_equal(result_o, expected_product(op, a, b), $sformatf("%s result", op.name()));
    check_equal(cmp_o, 1'b0, "flag on multiply");
    @(negedge clk);
    check_equal(valid_o, 1'b0, "second valid_o on multiply");
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int unsigned seed_dummy;
    logic [31:0] a;
    md_op_e      mop;
    issue_i     = 1'b0;
    is_mult_i   = 1'b0;
    alu_op_i    = ALU_ADD;
    md_op_i     = MD_MUL;
    operand_a_i = '0;
    operand_b_i = '0;
    reset_i     = 1'b1;
    seed_dummy  = $urandom(32'hca5f);
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;

    for (int i = 0; i < N_ARITH; i++)
      run_alu(arith_ops[$urandom_range(4, 0)], $urandom, $urandom);
    // upper bits of b must not leak into the amount
    for (int i = 0; i < N_SHIFT; i++)
      run_alu(shift_ops[$urandom_range(2, 0)], $urandom, $urandom);

    for (int k = 0; k < 14; k++)
    begin
      for (int e = 0; e < 8; e++)
        run_alu(cmp_ops[k], edge_a[e], edge_b[e]);
      a = $urandom;
      run_alu(cmp_ops[k], a, a);
      repeat (3) run_alu(cmp_ops[k], $urandom, $urandom);
    end

    for (int i = 0; i < N_MUL; i++)
      run_mult(md_op_e'($urandom_range(1, 0)), $urandom, $urandom, 0);
    for (int m = 0; m < 2; m++)
    begin
      mop = md_op_e'(m);
      run_mult(mop, 32'h0, $urandom, 0);
      run_mult(mop, $urandom, 32'h0, 0);
      run_mult(mop, 32'hffff_ffff, 32'hffff_ffff, 0);
      run_mult(mop, 32'hffff_ffff, 32'h1, 0);
    end
    for (int i = 0; i < N_BUSY; i++)
      run_mult(md_op_e'($urandom_range(1, 0)), $urandom, $urandom, $urandom_range(8, 1));

    // reset in the middle of a multiply
    @(posedge clk);
    issue_i     <= 1'b1;
    is_mult_i   <= 1'b1;
    md_op_i     <= MD_MULHU;
    operand_a_i <= $urandom;
    operand_b_i <= $urandom;
    @(posedge clk);
    issue_i <= 1'b0;
    repeat (10) @(posedge clk);
    reset_i <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_equal(valid_o, 1'b0, "valid_o after reset");
    check_equal(busy_o, 1'b0, "busy_o after reset");
    check_equal(result_o, 32'h0, "result_o after reset");
    run_alu(ALU_ADD, $urandom, $urandom);

    if (dut.u_asserts.fail_cnt == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("TEST FAIL");
      $fatal(1, "assertions failed");
    end
  end

endmodule
